/* Bender.yml */
package:
  name: fifo_subsys

sources:
  # Packages first, then interface and RTL in dependency order
  - hw/fifo_pkg.sv
  - hw/xfer_pkg.sv
  - hw/fifo_wr_if.sv
  - hw/fifo_ctrl_fsm.sv
  - hw/fifo_small.sv
  - hw/hs_ingress.sv
  - hw/hs_egress.sv
  - hw/fifo_subsys.sv

  # Testbench, top module tb_fifo_subsys
  - target: test
    files:
      - bench/tb_fifo_subsys.sv

/* bench/tb_fifo_subsys.sv */
// Word buffer testbench with stimulus table, producer, consumer, reference model, protocol monitor
`timescale 1ns/1ps

module tb_fifo_subsys;

    // -------------------------------------------------------------------------
    // Run constants and table layout
    // -------------------------------------------------------------------------
    localparam int DEPTH      = fifo_pkg::FIFO_DEPTH;
    localparam int N_ORDER    = 6;
    localparam int N_STALL    = DEPTH + 3;
    localparam int N_ROWS     = N_ORDER + N_STALL;
    localparam int N_RAND     = 30;
    localparam int RST_CYCLES = 16;
    localparam int MAX_CYCLES = 40 * (N_ROWS + N_RAND) + RST_CYCLES;

    // Data word, producer gap in cycles, consumer stall
    typedef struct packed {
        xfer_pkg::word_t data;
        logic [3:0]      gap;
        logic            stall;
    } row_t;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 in_req;
    xfer_pkg::word_t      in_data;
    logic                 in_ack;
    logic                 out_req;
    xfer_pkg::word_t      out_data;
    logic                 out_ack;
    xfer_pkg::drop_cnt_t  drop_count;

    // Reference model of FIFO contents and words due on the output link
    xfer_pkg::word_t      fifo_model [$];
    xfer_pkg::word_t      exp_out [$];
    xfer_pkg::egr_state_t egr_model;
    logic                 hold_model;
    logic                 pop_now;
    logic                 wr_now;
    int                   drops_model;

    // Consumer controls and bookkeeping
    logic                 stall;
    int                   ack_delay;
    int                   out_count;
    int                   cycles = 0;
    logic [31:0]          seed;

    // Port values from the previous rising edge
    logic                 prev_valid;
    logic                 p_in_req;
    logic                 p_in_ack;
    logic                 p_out_req;
    logic                 p_out_ack;
    xfer_pkg::word_t      p_out_data;

    fifo_subsys fifo_subsys_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_req     (in_req),
        .in_data    (in_data),
        .in_ack     (in_ack),
        .out_req    (out_req),
        .out_data   (out_data),
        .out_ack    (out_ack),
        .drop_count (drop_count)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // -------------------------------------------------------------------------
    // Helpers
    // -------------------------------------------------------------------------

    // Ordered traffic first and then a burst into a stalled consumer
    function automatic row_t table_row(input int idx);
        case (idx)
            0:       table_row = {16'h1234, 4'd0, 1'b0};
            1:       table_row = {16'hABCD, 4'd2, 1'b0};
            2:       table_row = {16'h0000, 4'd0, 1'b0};
            3:       table_row = {16'hFFFF, 4'd1, 1'b0};
            4:       table_row = {16'h5A5A, 4'd3, 1'b0};
            5:       table_row = {16'hA5A5, 4'd0, 1'b0};
            default: table_row = {8'hC0, idx[7:0], 4'd0, 1'b1};
        endcase
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        lcg_next = s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error at time %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // One four-phase transfer on the input link, then the gap
    task automatic send_word(input xfer_pkg::word_t data, input int gap);
        in_data = data;
        in_req  = 1'b1;
        @(negedge clk);
        while (!in_ack) @(negedge clk);
        in_req = 1'b0;
        @(negedge clk);
        while (in_ack) @(negedge clk);
        repeat (gap) @(negedge clk);
    endtask

    task automatic apply_rows(input int first, input int last);
        row_t row;
        for (int i = first; i < last; i++) begin
            row   = table_row(i);
            stall = row.stall;
            send_word(row.data, row.gap);
        end
    endtask

    // Until buffer and output link are quiet
    task automatic wait_drain();
        while (fifo_model.size() != 0 || exp_out.size() != 0 || out_req || out_ack) begin
            @(negedge clk);
        end
    endtask

    task automatic report_section(input string label);
        fifo_pkg::fifo_state_t st;
        st = fifo_subsys_inst.fifo_small_inst.fifo_ctrl_fsm_inst.state;
        $display("%s: %0d words out, %0d dropped, FIFO %s", label, out_count,
                 drop_count, st.name());
    endtask

    // -------------------------------------------------------------------------
    // Reference model and protocol monitor
    // -------------------------------------------------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            hold_model  = 1'b0;
            egr_model   = xfer_pkg::EGR_IDLE;
            drops_model = 0;
            prev_valid  = 1'b0;
            fifo_model.delete();
            exp_out.delete();
        end else begin
            // Ports still hold what settled after the last falling edge
            check_value("in_ack", hold_model, in_ack);
            check_value("out_req", egr_model == xfer_pkg::EGR_OFFER, out_req);
            check_value("drop_count", drops_model, drop_count);
            if (prev_valid) begin
                check_value("in_ack rise with in_req low", 0, in_ack && !p_in_ack && !p_in_req);
                check_value("out_req fall before out_ack", 0,
                            p_out_req && !out_req && !p_out_ack);
                if (p_out_req && out_req) begin
                    check_value("out_data", p_out_data, out_data);
                end
            end
            // Idle egress takes the head word at this edge
            pop_now = (egr_model == xfer_pkg::EGR_IDLE) && (fifo_model.size() != 0);
            wr_now  = in_req && !hold_model;
            if (pop_now) begin
                exp_out.push_back(fifo_model.pop_front());
            end
            // DEPTH entries plus the word parked in out_data
            if (wr_now) begin
                if (fifo_model.size() < DEPTH) begin
                    fifo_model.push_back(in_data);
                end else begin
                    drops_model++;
                end
            end
            hold_model = in_req;
            case (egr_model)
                xfer_pkg::EGR_IDLE:    if (pop_now) egr_model = xfer_pkg::EGR_OFFER;
                xfer_pkg::EGR_OFFER:   if (out_ack) egr_model = xfer_pkg::EGR_RELEASE;
                default:               if (!out_ack) egr_model = xfer_pkg::EGR_IDLE;
            endcase
            p_in_req   = in_req;
            p_in_ack   = in_ack;
            p_out_req  = out_req;
            p_out_ack  = out_ack;
            p_out_data = out_data;
            prev_valid = 1'b1;
        end
    end

    // Hang guard
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "Run stopped by cycle limit");
        end
    end

    // Consumer side of the output link
    initial begin : consumer
        xfer_pkg::word_t expected;
        forever begin
            @(negedge clk);
            if (rst_n && out_req) begin
                check_value("word expected on output", 1, exp_out.size() != 0);
                expected = exp_out.pop_front();
                check_value("out_data", expected, out_data);
                out_count++;
                while (stall) @(negedge clk);
                repeat (ack_delay) @(negedge clk);
                out_ack = 1'b1;
                while (out_req) @(negedge clk);
                out_ack = 1'b0;
            end
        end
    end

    // -------------------------------------------------------------------------
    // Main sequence
    // -------------------------------------------------------------------------
    initial begin : main
        int base;
        int prior_drops;
        rst_n     = 1'b0;
        in_req    = 1'b0;
        in_data   = '0;
        out_ack   = 1'b0;
        stall     = 1'b0;
        ack_delay = 0;
        out_count = 0;
        seed      = 32'd18;

        // Outputs quiet during and right after reset
        for (int i = 0; i <= RST_CYCLES; i++) begin
            @(negedge clk);
            if (i == RST_CYCLES - 1) begin
                rst_n = 1'b1;
            end
            check_value("in_ack", 0, in_ack);
            check_value("out_req", 0, out_req);
            check_value("drop_count", 0, drop_count);
        end

        // Prompt consumer loses nothing
        apply_rows(0, N_ORDER);
        wait_drain();
        check_value("drop_count", 0, drop_count);
        check_value("words out", N_ORDER, out_count);
        report_section("Ordered traffic");

        // Stalled consumer with every word acked and the last two lost
        base = out_count;
        apply_rows(N_ORDER, N_ROWS);
        stall = 1'b0;
        wait_drain();
        check_value("drop_count", N_STALL - (DEPTH + 1), drop_count);
        check_value("words out", DEPTH + 1, out_count - base);
        report_section("Back-pressure");

        // Random gaps and ack delays of up to 7 cycles
        base        = out_count;
        prior_drops = drops_model;
        for (int i = 0; i < N_RAND; i++) begin
            seed      = lcg_next(seed);
            ack_delay = seed[30:28];
            seed      = lcg_next(seed);
            in_data   = seed[31:16];
            seed      = lcg_next(seed);
            send_word(in_data, seed[29:28]);
        end
        wait_drain();
        check_value("drop_count", drops_model, drop_count);
        check_value("words out", N_RAND - (drops_model - prior_drops), out_count - base);
        report_section("Random traffic");

        $display("TEST PASS");
        $finish;
    end

endmodule : tb_fifo_subsys

/* compile.f */
hw/fifo_pkg.sv
hw/xfer_pkg.sv
hw/fifo_wr_if.sv
hw/fifo_ctrl_fsm.sv
hw/fifo_small.sv
hw/hs_ingress.sv
hw/hs_egress.sv
hw/fifo_subsys.sv
bench/tb_fifo_subsys.sv

/* hw/fifo_ctrl_fsm.sv */
// FIFO pointer and flag controller with overflow detection and write/read qualification
`timescale 1ns/1ps

module fifo_ctrl_fsm #(
    parameter int DEPTH = fifo_pkg::FIFO_DEPTH
) (
    input  logic                clk,
    input  logic                rst_n,

    // Raw requests
    input  logic                wr,
    input  logic                rd,

    // Qualified requests
    output logic                wr_safe,
    output logic                rd_safe,

    // Array addresses
    output fifo_pkg::fifo_ptr_t wr_ptr,
    output fifo_pkg::fifo_ptr_t rd_ptr,

    // Status
    output logic                full,
    output logic                empty,
    output logic                oflow
);

    // -------------------------------------------------------------------------
    // Signals
    // -------------------------------------------------------------------------
    fifo_pkg::fifo_cnt_t   cnt;
    fifo_pkg::fifo_cnt_t   cnt_next;
    fifo_pkg::fifo_state_t state;
    fifo_pkg::fifo_state_t state_next;

    // Wrap at DEPTH rather than at the power of two
    function automatic fifo_pkg::fifo_ptr_t ptr_inc(input fifo_pkg::fifo_ptr_t ptr);
        ptr_inc = (ptr == fifo_pkg::fifo_ptr_t'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // -------------------------------------------------------------------------
    // Qualification
    // -------------------------------------------------------------------------

    // Reads ignored when empty
    assign rd_safe = rd && !empty;

    // A simultaneous read frees the slot, so a full FIFO can still take a write
    assign wr_safe = wr && (!full || rd_safe);

    // Refused write, word is dropped
    assign oflow = wr && !wr_safe;

    // Flags straight off the state register
    assign full  = (state == fifo_pkg::FULL);
    assign empty = (state == fifo_pkg::EMPTY);

    // -------------------------------------------------------------------------
    // Occupancy and next state
    // -------------------------------------------------------------------------
    always_comb begin
        cnt_next = cnt;
        if (wr_safe && !rd_safe) begin
            cnt_next = cnt + 1'b1;
        end else if (rd_safe && !wr_safe) begin
            cnt_next = cnt - 1'b1;
        end
    end

    always_comb begin
        if (cnt_next == '0) begin
            state_next = fifo_pkg::EMPTY;
        end else if (cnt_next == fifo_pkg::fifo_cnt_t'(DEPTH)) begin
            state_next = fifo_pkg::FULL;
        end else begin
            state_next = fifo_pkg::PARTIAL;
        end
    end

    // -------------------------------------------------------------------------
    // Registers
    // -------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
            state  <= fifo_pkg::EMPTY;
        end else begin
            // Pointers move only on accepted accesses
            if (wr_safe) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_safe) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            cnt   <= cnt_next;
            state <= state_next;
        end
    end

endmodule : fifo_ctrl_fsm

/* hw/fifo_pkg.sv */
// FIFO geometry, pointer and occupancy types, controller state enum
package fifo_pkg;

    // -------------------------------------------------------------------------
    // Geometry
    // -------------------------------------------------------------------------

    // Storage entries in the word buffer
    localparam int FIFO_DEPTH = 4;

    // Pointer width, at least one bit for a single-entry FIFO
    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    // -------------------------------------------------------------------------
    // Types
    // -------------------------------------------------------------------------

    // Read or write pointer into the storage array
    typedef logic [PTR_W-1:0] fifo_ptr_t;

    // Occupancy, one extra bit so a count of FIFO_DEPTH fits
    typedef logic [PTR_W:0] fifo_cnt_t;

    // Controller state, doubles as the source of the full/empty flags
    typedef enum logic [1:0] {
        EMPTY   = 2'd0,
        PARTIAL = 2'd1,
        FULL    = 2'd2
    } fifo_state_t;

endpackage : fifo_pkg

/* hw/fifo_small.sv */
// Small synchronous FIFO with register-array storage and single-cycle write-to-read latency
`timescale 1ns/1ps

module fifo_small #(
    parameter type DATA_T = logic [15:0],
    parameter int  DEPTH  = fifo_pkg::FIFO_DEPTH
) (
    input  logic   clk,
    input  logic   rst_n,

    // Write side through the interface
    fifo_wr_if.fifo wr_port,

    // Read side
    input  logic   rd,
    output DATA_T  rd_data,
    output logic   empty
);

    // -------------------------------------------------------------------------
    // Signals
    // -------------------------------------------------------------------------
    DATA_T               mem [DEPTH];
    logic                wr_safe;
    fifo_pkg::fifo_ptr_t wr_ptr;
    fifo_pkg::fifo_ptr_t rd_ptr;

    // -------------------------------------------------------------------------
    // Controller
    // -------------------------------------------------------------------------
    fifo_ctrl_fsm #(
        .DEPTH   (DEPTH)
    ) fifo_ctrl_fsm_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (wr_port.wr),
        .rd      (rd),
        .wr_safe (wr_safe),
        .rd_safe (),
        .wr_ptr  (wr_ptr),
        .rd_ptr  (rd_ptr),
        .full    (wr_port.full),
        .empty   (empty),
        .oflow   (wr_port.oflow)
    );

    // Registered write, refused words never land
    always_ff @(posedge clk) begin
        if (wr_safe) begin
            mem[wr_ptr] <= wr_port.wr_data;
        end
    end

    // Head of queue, valid while empty is low
    assign rd_data = mem[rd_ptr];

endmodule : fifo_small

/* hw/fifo_subsys.sv */
// Word buffer top level joining ingress link, small FIFO and egress link
`timescale 1ns/1ps

module fifo_subsys (
    input  logic                clk,
    input  logic                rst_n,

    // Producer link
    input  logic                in_req,
    input  xfer_pkg::word_t     in_data,
    output logic                in_ack,

    // Consumer link
    output logic                out_req,
    output xfer_pkg::word_t     out_data,
    input  logic                out_ack,

    // Overflow statistics
    output xfer_pkg::drop_cnt_t drop_count
);

    // -------------------------------------------------------------------------
    // Internal wiring
    // -------------------------------------------------------------------------
    fifo_wr_if       wr_if ();
    logic            rd;
    xfer_pkg::word_t rd_data;
    logic            empty;

    // Decode of the input handshake
    hs_ingress hs_ingress_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_req     (in_req),
        .in_data    (in_data),
        .in_ack     (in_ack),
        .wr_port    (wr_if.writer),
        .drop_count (drop_count)
    );

    // Buffering stage
    fifo_small #(
        .DATA_T  (xfer_pkg::word_t),
        .DEPTH   (fifo_pkg::FIFO_DEPTH)
    ) fifo_small_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_port (wr_if.fifo),
        .rd      (rd),
        .rd_data (rd_data),
        .empty   (empty)
    );

    // Result side, drives the consumer
    hs_egress hs_egress_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd       (rd),
        .rd_data  (rd_data),
        .empty    (empty),
        .out_req  (out_req),
        .out_data (out_data),
        .out_ack  (out_ack)
    );

endmodule : fifo_subsys

/* hw/fifo_wr_if.sv */
// FIFO write port interface with writer and FIFO modports
`timescale 1ns/1ps

interface fifo_wr_if;

    // One-cycle write strobe
    logic              wr;
    // Word to store with the strobe
    xfer_pkg::word_t   wr_data;
    // Registered full flag from the controller
    logic              full;
    // Pulses with a wr that met a full FIFO
    logic              oflow;

    // Producer side, ingress block
    modport writer (
        output wr,
        output wr_data,
        input  full,
        input  oflow
    );

    // Storage side
    modport fifo (
        input  wr,
        input  wr_data,
        output full,
        output oflow
    );

endinterface : fifo_wr_if

/* hw/hs_egress.sv */
// Four-phase link sender popping the FIFO head into a registered output word
`timescale 1ns/1ps

module hs_egress (
    input  logic            clk,
    input  logic            rst_n,

    // FIFO read port
    output logic            rd,
    input  xfer_pkg::word_t rd_data,
    input  logic            empty,

    // Output link
    output logic            out_req,
    output xfer_pkg::word_t out_data,
    input  logic            out_ack
);

    // -------------------------------------------------------------------------
    // Handshake FSM
    // -------------------------------------------------------------------------
    xfer_pkg::egr_state_t state;

    // Pop only from IDLE, so the next word waits for ack release
    assign rd = (state == xfer_pkg::EGR_IDLE) && !empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= xfer_pkg::EGR_IDLE;
        end else begin
            case (state)
                // Head available, take it and request
                xfer_pkg::EGR_IDLE: begin
                    if (!empty) begin
                        state <= xfer_pkg::EGR_OFFER;
                    end
                end
                // Consumer may stall here indefinitely
                xfer_pkg::EGR_OFFER: begin
                    if (out_ack) begin
                        state <= xfer_pkg::EGR_RELEASE;
                    end
                end
                // Req already low, wait for ack to drop
                xfer_pkg::EGR_RELEASE: begin
                    if (!out_ack) begin
                        state <= xfer_pkg::EGR_IDLE;
                    end
                end
                default: state <= xfer_pkg::EGR_IDLE;
            endcase
        end
    end

    assign out_req = (state == xfer_pkg::EGR_OFFER);

    // -------------------------------------------------------------------------
    // Output word
    // -------------------------------------------------------------------------

    // Loaded with the pop, stable for the whole offer
    always_ff @(posedge clk) begin
        if (rd) begin
            out_data <= rd_data;
        end
    end

endmodule : hs_egress

/* hw/hs_ingress.sv */
// Four-phase link receiver feeding the FIFO write port, with saturating drop counter
`timescale 1ns/1ps

module hs_ingress (
    input  logic                clk,
    input  logic                rst_n,

    // Input link
    input  logic                in_req,
    input  xfer_pkg::word_t     in_data,
    output logic                in_ack,

    // FIFO write port
    fifo_wr_if.writer           wr_port,

    // Words lost to a full FIFO
    output xfer_pkg::drop_cnt_t drop_count
);

    // -------------------------------------------------------------------------
    // Handshake FSM
    // -------------------------------------------------------------------------
    xfer_pkg::ing_state_t state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= xfer_pkg::ING_IDLE;
        end else begin
            case (state)
                // New request, word goes out this cycle
                xfer_pkg::ING_IDLE: begin
                    if (in_req) begin
                        state <= xfer_pkg::ING_HOLD;
                    end
                end
                // Hold ack until producer lets go
                xfer_pkg::ING_HOLD: begin
                    if (!in_req) begin
                        state <= xfer_pkg::ING_IDLE;
                    end
                end
                default: state <= xfer_pkg::ING_IDLE;
            endcase
        end
    end

    // Ack follows the state, so it rises one edge after req is seen
    assign in_ack = (state == xfer_pkg::ING_HOLD);

    // One write per transfer, data taken straight from the link
    assign wr_port.wr      = (state == xfer_pkg::ING_IDLE) && in_req;
    assign wr_port.wr_data = in_data;

    // -------------------------------------------------------------------------
    // Drop counter
    // -------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            drop_count <= '0;
        end else if (wr_port.oflow && drop_count != xfer_pkg::DROP_CNT_MAX) begin
            drop_count <= drop_count + 1'b1;
        end
    end

endmodule : hs_ingress

/* hw/xfer_pkg.sv */
// Payload word type, drop-count type and saturation value, link handshake state enums
package xfer_pkg;

    // -------------------------------------------------------------------------
    // Payload and statistics
    // -------------------------------------------------------------------------

    // Word carried over both links and through the FIFO
    typedef logic [15:0] word_t;

    // Count of words lost to a full FIFO
    typedef logic [7:0] drop_cnt_t;

    // Counter sticks here
    localparam drop_cnt_t DROP_CNT_MAX = '1;

    // -------------------------------------------------------------------------
    // Handshake state machines
    // -------------------------------------------------------------------------

    // Receiving side of the input link
    typedef enum logic {
        ING_IDLE = 1'b0,
        ING_HOLD = 1'b1
    } ing_state_t;

    // Requesting side of the output link
    typedef enum logic [1:0] {
        EGR_IDLE    = 2'd0,
        EGR_OFFER   = 2'd1,
        EGR_RELEASE = 2'd2
    } egr_state_t;

endpackage : xfer_pkg
